// File: verilog/memCtrlPkg.sv
package memCtrlPkg;

    // Cache word and AXI data share one width
    localparam int busWidth = 128;
    localparam int strbBits = busWidth / 8;
    localparam int beatSize = $clog2(strbBits);

    // Line geometry
    localparam int lineBeats = 4;
    localparam int beatBits = 2;
    localparam int lineIdxBits = 8;
    localparam int cacheAddrBits = lineIdxBits + beatBits;
    localparam int lineOffsetBits = beatBits + beatSize;

    localparam int extAddrBits = 32;

    // Bus ID field, sized for the largest slot count of 16
    localparam int axiIdBits = 4;

    typedef enum logic [1:0] {
        MEMC_NONE,
        MEMC_FILL,
        MEMC_EVICT,
        MEMC_REPLACE
    } MemCmd;

    typedef enum logic [1:0] {
        FIXED,
        INCR,
        WRAP
    } BurstType;

    typedef struct packed {
        MemCmd cmd;
        logic [lineIdxBits-1:0] lineIdx;
        logic [extAddrBits-1:0] readAddr;
        logic [extAddrBits-1:0] writeAddr;
    } MemReq;

    // Shared by AR and AW
    typedef struct packed {
        logic [axiIdBits-1:0] id;
        logic [extAddrBits-1:0] addr;
        logic [7:0] len;
        logic [2:0] size;
        BurstType burst;
    } AxiAddr;

    typedef struct packed {
        logic [axiIdBits-1:0] id;
        logic [busWidth-1:0] data;
        logic last;
    } AxiR;

    typedef struct packed {
        logic [busWidth-1:0] data;
        logic [strbBits-1:0] strb;
        logic last;
    } AxiW;

    typedef struct packed {
        logic en;
        logic [cacheAddrBits-1:0] addr;
        logic [busWidth-1:0] data;
    } CacheWr;

    typedef struct packed {
        logic en;
        logic [cacheAddrBits-1:0] addr;
    } CacheRd;

    typedef struct packed {
        logic [axiIdBits-1:0] id;
        logic [lineIdxBits-1:0] lineIdx;
    } EvictJob;

endpackage

// File: verilog/transferTable.sv
`timescale 1ns/1ps

module transferTable
    import memCtrlPkg::*;
#(
    parameter int numSlots = 4,
    localparam int idBits = $clog2(numSlots)
) (
    input  logic clk,
    input  logic rst,
    input  MemReq req,
    output logic reqStall,
    output logic busy,
    output AxiAddr ar,
    output logic arValid,
    input  logic arReady,
    output AxiAddr aw,
    output logic awValid,
    input  logic awReady,
    input  logic bValid,
    input  logic [axiIdBits-1:0] bId,
    output EvictJob evictJob,
    output logic evictJobValid,
    input  logic evictJobReady,
    input  logic evictBeatValid,
    input  logic [idBits-1:0] evictBeatId,
    input  logic [idBits-1:0] fillHeadId,
    input  logic [beatBits-1:0] fillHeadBeat,
    output logic fillAllowed,
    output logic [cacheAddrBits-1:0] fillAddr,
    input  logic fillAckValid,
    input  logic [idBits-1:0] fillAckId
);

    localparam logic [beatBits:0] fullCount = (beatBits + 1)'(lineBeats);
    localparam logic [beatBits:0] lastCount = fullCount - 1'b1;

    typedef struct packed {
        logic valid;
        MemCmd cmd;
        logic [lineIdxBits-1:0] lineIdx;
        logic [extAddrBits-1:0] readAddr;
        logic [extAddrBits-1:0] writeAddr;
        logic [beatBits:0] evictProgress;
        logic [beatBits:0] fillProgress;
        logic needAr;
        logic needAw;
        logic needEvict;
        logic bDone;
    } Slot;

    Slot slots [numSlots];

    logic [idBits-1:0] freeIdx;
    logic freeFound;
    logic collision;
    logic accept;
    logic [idBits-1:0] arIdx;
    logic [idBits-1:0] arLockIdx;
    logic arLocked;
    logic [idBits-1:0] wrIdx;
    logic [idBits-1:0] wrLockIdx;
    logic wrLocked;
    logic wrFound;
    logic [idBits-1:0] bSlot;
    logic [numSlots-1:0] freeNow;

    function automatic logic [extAddrBits-1:0] lineAlign(logic [extAddrBits-1:0] addr);
        return {addr[extAddrBits-1:lineOffsetBits], {lineOffsetBits{1'b0}}};
    endfunction

    function automatic AxiAddr lineBurst(logic [idBits-1:0] id, logic [extAddrBits-1:0] addr);
        AxiAddr a;
        a.id = axiIdBits'(id);
        a.addr = addr;
        a.len = 8'(lineBeats - 1);
        a.size = 3'(beatSize);
        a.burst = WRAP;
        return a;
    endfunction

    // Lowest free slot, and whether any live slot owns the requested line
    always_comb begin
        freeIdx = '0;
        freeFound = 1'b0;
        collision = 1'b0;
        busy = 1'b0;
        for (int i = numSlots - 1; i >= 0; i--) begin
            if (!slots[i].valid) begin
                freeIdx = idBits'(i);
                freeFound = 1'b1;
            end
            if (slots[i].valid && slots[i].lineIdx == req.lineIdx) begin
                collision = 1'b1;
            end
            busy = busy | slots[i].valid;
        end
    end

    assign reqStall = !freeFound || collision;
    assign accept = req.cmd != MEMC_NONE && !reqStall;

    // AR stays on its slot until the handshake
    always_comb begin
        arIdx = '0;
        arValid = 1'b0;
        for (int i = numSlots - 1; i >= 0; i--) begin
            if (slots[i].valid && slots[i].needAr) begin
                arIdx = idBits'(i);
                arValid = 1'b1;
            end
        end
        if (arLocked) begin
            arIdx = arLockIdx;
            arValid = 1'b1;
        end
    end

    assign ar = lineBurst(arIdx, slots[arIdx].readAddr);

    // AW and evict job share one pick so both sides see the same slot order
    always_comb begin
        wrIdx = '0;
        wrFound = 1'b0;
        for (int i = numSlots - 1; i >= 0; i--) begin
            if (slots[i].valid && (slots[i].needAw || slots[i].needEvict)) begin
                wrIdx = idBits'(i);
                wrFound = 1'b1;
            end
        end
        // A slot with only one side issued goes first
        for (int i = numSlots - 1; i >= 0; i--) begin
            if (slots[i].valid && (slots[i].needAw != slots[i].needEvict)) begin
                wrIdx = idBits'(i);
            end
        end
        if (wrLocked) begin
            wrIdx = wrLockIdx;
            wrFound = 1'b1;
        end
    end

    assign awValid = wrFound && slots[wrIdx].needAw;
    assign aw = lineBurst(wrIdx, slots[wrIdx].writeAddr);
    assign evictJobValid = wrFound && slots[wrIdx].needEvict;
    assign evictJob.id = axiIdBits'(wrIdx);
    assign evictJob.lineIdx = slots[wrIdx].lineIdx;

    // Fill beat may overwrite the cache only after the evict has read it
    assign fillAddr = {slots[fillHeadId].lineIdx, fillHeadBeat};
    assign fillAllowed = slots[fillHeadId].valid &&
        (slots[fillHeadId].cmd != MEMC_REPLACE ||
         slots[fillHeadId].evictProgress > {1'b0, fillHeadBeat});

    assign bSlot = bId[idBits-1:0];

    // Slot done once all fill acks and the B response are in
    always_comb begin
        for (int i = 0; i < numSlots; i++) begin
            freeNow[i] = slots[i].valid &&
                (slots[i].cmd == MEMC_EVICT || slots[i].fillProgress == fullCount ||
                 (fillAckValid && fillAckId == idBits'(i) &&
                  slots[i].fillProgress == lastCount)) &&
                (slots[i].cmd == MEMC_FILL || slots[i].bDone ||
                 (bValid && bSlot == idBits'(i)));
        end
    end

    always_ff @(posedge clk) begin
        arLockIdx <= arIdx;
        wrLockIdx <= wrIdx;
        if (rst) begin
            for (int i = 0; i < numSlots; i++) begin
                slots[i].valid <= 1'b0;
                slots[i].needAr <= 1'b0;
                slots[i].needAw <= 1'b0;
                slots[i].needEvict <= 1'b0;
            end
            arLocked <= 1'b0;
            wrLocked <= 1'b0;
        end else begin
            arLocked <= arValid && !arReady;
            wrLocked <= (awValid && !awReady) || (evictJobValid && !evictJobReady);

            for (int i = 0; i < numSlots; i++) begin
                if (freeNow[i]) begin
                    slots[i].valid <= 1'b0;
                end
            end

            if (accept) begin
                slots[freeIdx].valid <= 1'b1;
                slots[freeIdx].cmd <= req.cmd;
                slots[freeIdx].lineIdx <= req.lineIdx;
                slots[freeIdx].readAddr <= lineAlign(req.readAddr);
                slots[freeIdx].writeAddr <= lineAlign(req.writeAddr);
                slots[freeIdx].evictProgress <= '0;
                slots[freeIdx].fillProgress <= '0;
                slots[freeIdx].needAr <= req.cmd != MEMC_EVICT;
                slots[freeIdx].needAw <= req.cmd != MEMC_FILL;
                slots[freeIdx].needEvict <= req.cmd != MEMC_FILL;
                slots[freeIdx].bDone <= 1'b0;
            end

            if (arValid && arReady) begin
                slots[arIdx].needAr <= 1'b0;
            end
            if (awValid && awReady) begin
                slots[wrIdx].needAw <= 1'b0;
            end
            if (evictJobValid && evictJobReady) begin
                slots[wrIdx].needEvict <= 1'b0;
            end
            if (evictBeatValid) begin
                slots[evictBeatId].evictProgress <= slots[evictBeatId].evictProgress + 1'b1;
            end
            if (fillAckValid) begin
                slots[fillAckId].fillProgress <= slots[fillAckId].fillProgress + 1'b1;
            end
            if (bValid) begin
                slots[bSlot].bDone <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/fillPath.sv
`timescale 1ns/1ps

module fillPath
    import memCtrlPkg::*;
#(
    parameter int numSlots = 4,
    localparam int idBits = $clog2(numSlots)
) (
    input  logic clk,
    input  logic rst,
    input  AxiR r,
    input  logic rValid,
    output logic rReady,
    output logic [idBits-1:0] fillHeadId,
    output logic [beatBits-1:0] fillHeadBeat,
    input  logic fillAllowed,
    input  logic [cacheAddrBits-1:0] fillAddr,
    output CacheWr cacheWr,
    output logic fillAckValid,
    output logic [idBits-1:0] fillAckId
);

    typedef struct packed {
        logic [idBits-1:0] id;
        logic [beatBits-1:0] beat;
        logic [busWidth-1:0] data;
    } RBeat;

    RBeat entries [2];
    logic wrPtr;
    logic rdPtr;
    logic [1:0] count;
    logic push;
    logic pop;
    logic [idBits-1:0] rId;
    logic [beatBits-1:0] beatCnt [numSlots];

    logic wrEn;
    logic [cacheAddrBits-1:0] wrAddr;
    logic [busWidth-1:0] wrData;
    logic [idBits-1:0] wrId;

    assign rId = r.id[idBits-1:0];
    assign rReady = count != 2'd2;
    assign push = rValid && rReady;
    assign pop = count != 2'd0 && fillAllowed;

    assign fillHeadId = entries[rdPtr].id;
    assign fillHeadBeat = entries[rdPtr].beat;

    // Beat position per ID, since bursts of different IDs may interleave
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            count <= 2'd0;
            for (int i = 0; i < numSlots; i++) begin
                beatCnt[i] <= '0;
            end
        end else begin
            if (push) begin
                wrPtr <= !wrPtr;
                beatCnt[rId] <= r.last ? '0 : beatCnt[rId] + 1'b1;
            end
            if (pop) begin
                rdPtr <= !rdPtr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= '{id: rId, beat: beatCnt[rId], data: r.data};
        end
    end

    // Write one cycle after the pop, ack one cycle after the write
    always_ff @(posedge clk) begin
        if (pop) begin
            wrAddr <= fillAddr;
            wrData <= entries[rdPtr].data;
            wrId <= fillHeadId;
        end
        fillAckId <= wrId;
        if (rst) begin
            wrEn <= 1'b0;
            fillAckValid <= 1'b0;
        end else begin
            wrEn <= pop;
            fillAckValid <= wrEn;
        end
    end

    assign cacheWr = '{en: wrEn, addr: wrAddr, data: wrData};

endmodule

// File: verilog/evictPath.sv
`timescale 1ns/1ps

module evictPath
    import memCtrlPkg::*;
#(
    parameter int numSlots = 4,
    localparam int idBits = $clog2(numSlots)
) (
    input  logic clk,
    input  logic rst,
    input  EvictJob evictJob,
    input  logic evictJobValid,
    output logic evictJobReady,
    output CacheRd cacheRd,
    input  logic [busWidth-1:0] cacheRdData,
    output logic evictBeatValid,
    output logic [idBits-1:0] evictBeatId,
    output AxiW w,
    output logic wValid,
    input  logic wReady
);

    localparam logic [beatBits-1:0] lastBeat = beatBits'(lineBeats - 1);

    typedef struct packed {
        logic [busWidth-1:0] data;
        logic last;
    } WBeat;

    logic active;
    logic [idBits-1:0] jobId;
    logic [lineIdxBits-1:0] jobLine;
    logic [beatBits-1:0] readBeat;
    logic jobTake;
    logic rdIssue;
    logic rdPending;
    logic rdPendingLast;
    logic [idBits-1:0] rdPendingId;

    WBeat fifo [2];
    logic wrPtr;
    logic rdPtr;
    logic [1:0] count;
    logic pop;

    assign evictJobReady = !active;
    assign jobTake = evictJobValid && !active;

    // A read in flight already holds its FIFO place
    assign rdIssue = active && (count + {1'b0, rdPending}) < 2'd2;
    assign cacheRd = '{en: rdIssue, addr: {jobLine, readBeat}};

    // Data comes back the cycle after the read
    assign evictBeatValid = rdPending;
    assign evictBeatId = rdPendingId;

    always_ff @(posedge clk) begin
        if (jobTake) begin
            jobId <= evictJob.id[idBits-1:0];
            jobLine <= evictJob.lineIdx;
        end
        if (rdIssue) begin
            rdPendingId <= jobId;
            rdPendingLast <= readBeat == lastBeat;
        end
        if (rst) begin
            active <= 1'b0;
            readBeat <= '0;
            rdPending <= 1'b0;
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            count <= 2'd0;
        end else begin
            rdPending <= rdIssue;
            if (jobTake) begin
                active <= 1'b1;
                readBeat <= '0;
            end else if (rdIssue) begin
                readBeat <= readBeat + 1'b1;
                if (readBeat == lastBeat) begin
                    active <= 1'b0;
                end
            end
            if (rdPending) begin
                wrPtr <= !wrPtr;
            end
            if (pop) begin
                rdPtr <= !rdPtr;
            end
            count <= count + {1'b0, rdPending} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (rdPending) begin
            fifo[wrPtr] <= '{data: cacheRdData, last: rdPendingLast};
        end
    end

    // Whole beats only, so every byte lane is written
    assign wValid = count != 2'd0;
    assign pop = wValid && wReady;
    assign w = '{data: fifo[rdPtr].data, strb: '1, last: fifo[rdPtr].last};

endmodule

// File: verilog/memCtrlTop.sv
`timescale 1ns/1ps

module memCtrlTop
    import memCtrlPkg::*;
#(
    parameter int numSlots = 4,
    localparam int idBits = $clog2(numSlots)
) (
    input  logic clk,
    input  logic rst,
    input  MemReq req,
    output logic reqStall,
    output logic busy,
    output AxiAddr ar,
    output logic arValid,
    input  logic arReady,
    output AxiAddr aw,
    output logic awValid,
    input  logic awReady,
    input  AxiR r,
    input  logic rValid,
    output logic rReady,
    output AxiW w,
    output logic wValid,
    input  logic wReady,
    input  logic bValid,
    input  logic [axiIdBits-1:0] bId,
    output logic bReady,
    output CacheWr cacheWr,
    output CacheRd cacheRd,
    input  logic [busWidth-1:0] cacheRdData
);

    EvictJob evictJob;
    logic evictJobValid;
    logic evictJobReady;
    logic evictBeatValid;
    logic [idBits-1:0] evictBeatId;
    logic [idBits-1:0] fillHeadId;
    logic [beatBits-1:0] fillHeadBeat;
    logic fillAllowed;
    logic [cacheAddrBits-1:0] fillAddr;
    logic fillAckValid;
    logic [idBits-1:0] fillAckId;

    // B is never back-pressured
    assign bReady = 1'b1;

    transferTable #(
        .numSlots(numSlots)
    ) slotTable (
        .clk(clk),
        .rst(rst),
        .req(req),
        .reqStall(reqStall),
        .busy(busy),
        .ar(ar),
        .arValid(arValid),
        .arReady(arReady),
        .aw(aw),
        .awValid(awValid),
        .awReady(awReady),
        .bValid(bValid),
        .bId(bId),
        .evictJob(evictJob),
        .evictJobValid(evictJobValid),
        .evictJobReady(evictJobReady),
        .evictBeatValid(evictBeatValid),
        .evictBeatId(evictBeatId),
        .fillHeadId(fillHeadId),
        .fillHeadBeat(fillHeadBeat),
        .fillAllowed(fillAllowed),
        .fillAddr(fillAddr),
        .fillAckValid(fillAckValid),
        .fillAckId(fillAckId)
    );

    fillPath #(
        .numSlots(numSlots)
    ) fillUnit (
        .clk(clk),
        .rst(rst),
        .r(r),
        .rValid(rValid),
        .rReady(rReady),
        .fillHeadId(fillHeadId),
        .fillHeadBeat(fillHeadBeat),
        .fillAllowed(fillAllowed),
        .fillAddr(fillAddr),
        .cacheWr(cacheWr),
        .fillAckValid(fillAckValid),
        .fillAckId(fillAckId)
    );

    evictPath #(
        .numSlots(numSlots)
    ) evictUnit (
        .clk(clk),
        .rst(rst),
        .evictJob(evictJob),
        .evictJobValid(evictJobValid),
        .evictJobReady(evictJobReady),
        .cacheRd(cacheRd),
        .cacheRdData(cacheRdData),
        .evictBeatValid(evictBeatValid),
        .evictBeatId(evictBeatId),
        .w(w),
        .wValid(wValid),
        .wReady(wReady)
    );

endmodule

// File: tests/axiMemModel.sv
`timescale 1ns/1ps

module axiMemModel
    import memCtrlPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic [3:0] gaps,
    input  logic initEn,
    input  logic [cacheAddrBits-1:0] initAddr,
    input  logic [busWidth-1:0] initData,
    input  AxiAddr ar,
    input  logic arValid,
    output logic arReady,
    input  AxiAddr aw,
    input  logic awValid,
    output logic awReady,
    output AxiR r,
    output logic rValid,
    input  logic rReady,
    input  AxiW w,
    input  logic wValid,
    output logic wReady,
    output logic bValid,
    output logic [axiIdBits-1:0] bId
);

    localparam int memWords = 1 << cacheAddrBits;
    localparam logic [beatBits-1:0] lastBeat = beatBits'(lineBeats - 1);

    logic [busWidth-1:0] memArr [memWords];
    AxiAddr arQ [$];
    AxiAddr awQ [$];
    logic [beatBits-1:0] rBeat = '0;
    logic [beatBits-1:0] wBeat = '0;
    logic awNotEmpty = 1'b0;
    AxiR rReg = '0;
    logic rValidReg = 1'b0;
    logic bValidReg = 1'b0;
    logic [axiIdBits-1:0] bIdReg = '0;

    // Word index from the line bits of the byte address
    function automatic logic [cacheAddrBits-1:0] wordIdx(logic [extAddrBits-1:0] addr,
                                                         logic [beatBits-1:0] beat);
        return {addr[lineOffsetBits +: lineIdxBits], beat};
    endfunction

    assign arReady = !gaps[0];
    assign awReady = !gaps[1];
    // W waits for its AW so the write address is known
    assign wReady = !gaps[2] && awNotEmpty;
    assign r = rReg;
    assign rValid = rValidReg;
    assign bValid = bValidReg;
    assign bId = bIdReg;

    always @(posedge clk) begin
        if (rst) begin
            rValidReg <= 1'b0;
            bValidReg <= 1'b0;
            rBeat <= '0;
            wBeat <= '0;
            arQ.delete();
            awQ.delete();
            awNotEmpty <= 1'b0;
        end else begin
            // R holds its beat until rready
            if (!rValidReg || rReady) begin
                if (arQ.size() != 0 && !gaps[3]) begin
                    rReg <= '{id: arQ[0].id, data: memArr[wordIdx(arQ[0].addr, rBeat)],
                              last: rBeat == lastBeat};
                    rValidReg <= 1'b1;
                    rBeat <= rBeat + 1'b1;
                    if (rBeat == lastBeat) begin
                        void'(arQ.pop_front());
                    end
                end else begin
                    rValidReg <= 1'b0;
                end
            end
            bValidReg <= 1'b0;
            if (wValid && wReady) begin
                memArr[wordIdx(awQ[0].addr, wBeat)] <= w.data;
                wBeat <= wBeat + 1'b1;
                if (wBeat == lastBeat) begin
                    bIdReg <= awQ[0].id;
                    bValidReg <= 1'b1;
                    void'(awQ.pop_front());
                end
            end
            if (arValid && arReady) begin
                arQ.push_back(ar);
            end
            if (awValid && awReady) begin
                awQ.push_back(aw);
            end
            awNotEmpty <= awQ.size() != 0;
        end
        if (initEn) begin
            memArr[initAddr] <= initData;
        end
    end

endmodule

// File: tests/memCtrlTb.sv
`timescale 1ns/1ps

module memCtrlTb;
    import memCtrlPkg::*;

    localparam int numSlots = 4;
    localparam int words = 1 << cacheAddrBits;
    localparam int waitLimit = 5000;

    logic clk;
    logic rst;
    MemReq req;
    logic reqStall;
    logic busy;
    AxiAddr ar;
    logic arValid;
    logic arReady;
    AxiAddr aw;
    logic awValid;
    logic awReady;
    AxiR r;
    logic rValid;
    logic rReady;
    AxiW w;
    logic wValid;
    logic wReady;
    logic bValid;
    logic [axiIdBits-1:0] bId;
    logic bReady;
    CacheWr cacheWr;
    CacheRd cacheRd;
    logic [busWidth-1:0] cacheRdData = '0;

    logic [3:0] gaps;
    logic gapsOn;
    logic initEn;
    logic [cacheAddrBits-1:0] initAddr;
    logic [busWidth-1:0] initMemData;
    logic [busWidth-1:0] initCacheData;

    logic [busWidth-1:0] cache [words];
    logic [busWidth-1:0] modelMem [words];
    logic [busWidth-1:0] modelCache [words];
    logic [31:0] lfsrState;
    logic [beatBits-1:0] wBeatSeen = '0;
    int errors;
    int checks;

    memCtrlTop #(
        .numSlots(numSlots)
    ) DUT (
        .clk(clk), .rst(rst), .req(req), .reqStall(reqStall), .busy(busy),
        .ar(ar), .arValid(arValid), .arReady(arReady),
        .aw(aw), .awValid(awValid), .awReady(awReady),
        .r(r), .rValid(rValid), .rReady(rReady),
        .w(w), .wValid(wValid), .wReady(wReady),
        .bValid(bValid), .bId(bId), .bReady(bReady),
        .cacheWr(cacheWr), .cacheRd(cacheRd), .cacheRdData(cacheRdData)
    );

    axiMemModel mem (
        .clk(clk), .rst(rst), .gaps(gaps),
        .initEn(initEn), .initAddr(initAddr), .initData(initMemData),
        .ar(ar), .arValid(arValid), .arReady(arReady),
        .aw(aw), .awValid(awValid), .awReady(awReady),
        .r(r), .rValid(rValid), .rReady(rReady),
        .w(w), .wValid(wValid), .wReady(wReady),
        .bValid(bValid), .bId(bId)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cache array with one cycle read latency
    always @(posedge clk) begin
        if (initEn) begin
            cache[initAddr] <= initCacheData;
        end else if (cacheWr.en) begin
            cache[cacheWr.addr] <= cacheWr.data;
        end
        if (cacheRd.en) begin
            cacheRdData <= cache[cacheRd.addr];
        end
    end

    task automatic checkValue(string name, logic [busWidth-1:0] expected,
                              logic [busWidth-1:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'hA300_0000 : lfsrState >> 1;
        end
        return v;
    endfunction

    function automatic logic [busWidth-1:0] randWord();
        return {randBits(32), randBits(32), randBits(32), randBits(32)};
    endfunction

    task automatic reportTimeout(string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic tick();
        @(posedge clk);
        gaps <= gapsOn ? 4'(randBits(4)) : 4'd0;
    endtask

    // Bus format checks on every AR, AW and W beat
    always @(negedge clk) begin
        if (!rst) begin
            if (arValid) begin
                checkValue("arLen", busWidth'(lineBeats - 1), busWidth'(ar.len));
                checkValue("arSize", busWidth'(4), busWidth'(ar.size));
                checkValue("arBurst", busWidth'(WRAP), busWidth'(ar.burst));
                checkValue("arAlign", '0, busWidth'(ar.addr[lineOffsetBits-1:0]));
            end
            if (awValid) begin
                checkValue("awLen", busWidth'(lineBeats - 1), busWidth'(aw.len));
                checkValue("awSize", busWidth'(4), busWidth'(aw.size));
                checkValue("awBurst", busWidth'(WRAP), busWidth'(aw.burst));
                checkValue("awAlign", '0, busWidth'(aw.addr[lineOffsetBits-1:0]));
            end
            if (wValid && wReady) begin
                checkValue("wLast", busWidth'(wBeatSeen == 2'd3), busWidth'(w.last));
                checkValue("wStrb", busWidth'(16'hFFFF), busWidth'(w.strb));
                wBeatSeen = wBeatSeen + 1'b1;
            end
        end
    end

    // Evict copies out before the fill overwrites the same line
    task automatic applyModel(MemCmd cmd, logic [lineIdxBits-1:0] line,
                              logic [31:0] raddr, logic [31:0] waddr);
        for (int b = 0; b < lineBeats; b++) begin
            if (cmd == MEMC_EVICT || cmd == MEMC_REPLACE) begin
                modelMem[{waddr[lineOffsetBits +: lineIdxBits], 2'(b)}] = modelCache[{line, 2'(b)}];
            end
        end
        for (int b = 0; b < lineBeats; b++) begin
            if (cmd == MEMC_FILL || cmd == MEMC_REPLACE) begin
                modelCache[{line, 2'(b)}] = modelMem[{raddr[lineOffsetBits +: lineIdxBits], 2'(b)}];
            end
        end
    endtask

    task automatic sendReq(MemCmd cmd, logic [lineIdxBits-1:0] line, logic [31:0] raddr,
                           logic [31:0] waddr, output int stalls);
        int n;
        logic stalled;
        n = 0;
        stalled = 1'b1;
        tick();
        req <= '{cmd: cmd, lineIdx: line, readAddr: raddr, writeAddr: waddr};
        while (stalled && n <= waitLimit) begin
            @(negedge clk);
            stalled = reqStall;
            tick();
            if (stalled) begin
                n++;
            end
        end
        req.cmd <= MEMC_NONE;
        stalls = n;
        if (stalled) begin
            reportTimeout("Request was never accepted before the timeout");
        end else begin
            applyModel(cmd, line, raddr, waddr);
        end
    endtask

    task automatic waitIdle();
        int n;
        logic idle;
        n = 0;
        idle = 1'b0;
        while (!idle && n <= waitLimit) begin
            @(negedge clk);
            idle = !busy;
            tick();
            n++;
        end
        if (!idle) begin
            reportTimeout("Controller stayed busy past the timeout");
        end
    endtask

    task automatic compareAll(string phase);
        for (int i = 0; i < words; i++) begin
            checkValue({phase, " cache"}, modelCache[i], cache[i]);
            checkValue({phase, " memory"}, modelMem[i], mem.memArr[i]);
        end
    endtask

    initial begin
        int stalls;
        MemCmd cmd;
        logic [lineIdxBits-1:0] line;
        logic [31:0] raddr;
        logic [31:0] waddr;
        lfsrState = 32'h991b;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        req = '0;
        gaps = 4'd0;
        gapsOn = 1'b0;
        initEn = 1'b0;
        initAddr = '0;
        initMemData = '0;
        initCacheData = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        repeat (4) begin
            @(negedge clk);
            checkValue("resetArValid", '0, busWidth'(arValid));
            checkValue("resetAwValid", '0, busWidth'(awValid));
            checkValue("resetWValid", '0, busWidth'(wValid));
            checkValue("resetCacheWr", '0, busWidth'(cacheWr.en));
            checkValue("resetCacheRd", '0, busWidth'(cacheRd.en));
            checkValue("resetBusy", '0, busWidth'(busy));
            checkValue("resetStall", '0, busWidth'(reqStall));
            checkValue("resetReady", busWidth'(2'b11), busWidth'({rReady, bReady}));
        end

        // Load memory and cache while the controller is idle
        for (int i = 0; i < words; i++) begin
            @(posedge clk);
            modelMem[i] = randWord();
            modelCache[i] = randWord();
            initEn <= 1'b1;
            initAddr <= cacheAddrBits'(i);
            initMemData <= modelMem[i];
            initCacheData <= modelCache[i];
        end
        @(posedge clk);
        initEn <= 1'b0;

        // Reads use memory lines 0 to 127 and writes use lines 128 and up
        sendReq(MEMC_FILL, 8'd3, 32'h0000_0554, 32'h0000_2000, stalls);
        waitIdle();
        compareAll("fill");
        sendReq(MEMC_EVICT, 8'd7, 32'h0000_0000, 32'h0000_21C8, stalls);
        waitIdle();
        compareAll("evict");
        sendReq(MEMC_REPLACE, 8'd9, 32'h0000_0F3C, 32'h0000_2240, stalls);
        waitIdle();
        compareAll("replace");

        sendReq(MEMC_FILL, 8'd12, 32'h0000_0A00, 32'h0000_0000, stalls);
        sendReq(MEMC_EVICT, 8'd12, 32'h0000_0000, 32'h0000_2300, stalls);
        checkValue("collisionStall", busWidth'(1), busWidth'(stalls > 0));
        waitIdle();
        compareAll("collision");

        gapsOn = 1'b1;
        for (int k = 0; k < 80; k++) begin
            cmd = MemCmd'(randBits(2));
            if (cmd == MEMC_NONE) begin
                cmd = MEMC_FILL;
            end
            line = {1'b0, 7'(randBits(7))};
            raddr = {18'd0, 1'b0, 7'(randBits(7)), 6'(randBits(6))};
            waddr = {18'd0, 1'b1, line[6:0], 6'(randBits(6))};
            sendReq(cmd, line, raddr, waddr, stalls);
        end
        waitIdle();
        gapsOn = 1'b0;
        compareAll("random");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
verilog/memCtrlPkg.sv
verilog/transferTable.sv
verilog/fillPath.sv
verilog/evictPath.sv
verilog/memCtrlTop.sv
tests/axiMemModel.sv
tests/memCtrlTb.sv

// File: run.sh
#!/bin/sh
# Build and run the memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module memCtrlTb -f sim.f -o memCtrlSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memCtrlSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
